// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;
    localparam int OPC_W = 6;
    localparam int FUNCT_W = 6;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    typedef union packed {
        struct packed {
            logic [OPC_W-1:0] opcode;
            reg_addr_t rs;
            reg_addr_t rt;
            reg_addr_t rd;
            logic [4:0] shamt;
            logic [FUNCT_W-1:0] funct;
        } r;
        struct packed {
            logic [OPC_W-1:0] opcode;
            reg_addr_t rs;
            reg_addr_t rt;
            logic [15:0] imm;
        } i;
    } instr_u;

    localparam logic [OPC_W-1:0] OPC_SPECIAL = 6'h00;
    localparam logic [OPC_W-1:0] OPC_REGIMM = 6'h01;
    localparam logic [OPC_W-1:0] OPC_J = 6'h02;
    localparam logic [OPC_W-1:0] OPC_JAL = 6'h03;
    localparam logic [OPC_W-1:0] OPC_BEQ = 6'h04;
    localparam logic [OPC_W-1:0] OPC_BNE = 6'h05;
    localparam logic [OPC_W-1:0] OPC_BLEZ = 6'h06;
    localparam logic [OPC_W-1:0] OPC_BGTZ = 6'h07;
    localparam logic [OPC_W-1:0] OPC_ADDI = 6'h08;
    localparam logic [OPC_W-1:0] OPC_ADDIU = 6'h09;
    localparam logic [OPC_W-1:0] OPC_SLTI = 6'h0a;
    localparam logic [OPC_W-1:0] OPC_SLTIU = 6'h0b;
    localparam logic [OPC_W-1:0] OPC_ANDI = 6'h0c;
    localparam logic [OPC_W-1:0] OPC_ORI = 6'h0d;
    localparam logic [OPC_W-1:0] OPC_XORI = 6'h0e;
    localparam logic [OPC_W-1:0] OPC_LUI = 6'h0f;
    localparam logic [OPC_W-1:0] OPC_SPECIAL2 = 6'h1c;
    localparam logic [OPC_W-1:0] OPC_LB = 6'h20;
    localparam logic [OPC_W-1:0] OPC_LH = 6'h21;
    localparam logic [OPC_W-1:0] OPC_LW = 6'h23;
    localparam logic [OPC_W-1:0] OPC_LBU = 6'h24;
    localparam logic [OPC_W-1:0] OPC_LHU = 6'h25;
    localparam logic [OPC_W-1:0] OPC_SB = 6'h28;
    localparam logic [OPC_W-1:0] OPC_SH = 6'h29;
    localparam logic [OPC_W-1:0] OPC_SW = 6'h2b;

    localparam logic [FUNCT_W-1:0] FN_SLL = 6'h00;
    localparam logic [FUNCT_W-1:0] FN_SRL = 6'h02;
    localparam logic [FUNCT_W-1:0] FN_SRA = 6'h03;
    localparam logic [FUNCT_W-1:0] FN_SLLV = 6'h04;
    localparam logic [FUNCT_W-1:0] FN_SRLV = 6'h06;
    localparam logic [FUNCT_W-1:0] FN_SRAV = 6'h07;
    localparam logic [FUNCT_W-1:0] FN_JR = 6'h08;
    localparam logic [FUNCT_W-1:0] FN_JALR = 6'h09;
    localparam logic [FUNCT_W-1:0] FN_MFHI = 6'h10;
    localparam logic [FUNCT_W-1:0] FN_MTHI = 6'h11;
    localparam logic [FUNCT_W-1:0] FN_MFLO = 6'h12;
    localparam logic [FUNCT_W-1:0] FN_MTLO = 6'h13;
    localparam logic [FUNCT_W-1:0] FN_MULT = 6'h18;
    localparam logic [FUNCT_W-1:0] FN_MULTU = 6'h19;
    localparam logic [FUNCT_W-1:0] FN_DIV = 6'h1a;
    localparam logic [FUNCT_W-1:0] FN_DIVU = 6'h1b;
    localparam logic [FUNCT_W-1:0] FN_ADD = 6'h20;
    localparam logic [FUNCT_W-1:0] FN_ADDU = 6'h21;
    localparam logic [FUNCT_W-1:0] FN_SUB = 6'h22;
    localparam logic [FUNCT_W-1:0] FN_SUBU = 6'h23;
    localparam logic [FUNCT_W-1:0] FN_AND = 6'h24;
    localparam logic [FUNCT_W-1:0] FN_OR = 6'h25;
    localparam logic [FUNCT_W-1:0] FN_XOR = 6'h26;
    localparam logic [FUNCT_W-1:0] FN_NOR = 6'h27;
    localparam logic [FUNCT_W-1:0] FN_SLT = 6'h2a;
    localparam logic [FUNCT_W-1:0] FN_SLTU = 6'h2b;
    localparam logic [FUNCT_W-1:0] FN2_MUL = 6'h02; // Funct code under SPECIAL2.

    localparam reg_addr_t RT_BLTZ = 5'h00; // REGIMM selects the branch through rt.
    localparam reg_addr_t RT_BGEZ = 5'h01;
    localparam reg_addr_t RT_BLTZAL = 5'h10;
    localparam reg_addr_t RT_BGEZAL = 5'h11;

    localparam reg_addr_t LINK_REG = 5'd31;
endpackage

`default_nettype wire

// ==== hdl/ctl_pkg.sv ====
`default_nettype none

package ctl_pkg;
    localparam int ALU_FUNC_W = 4;
    localparam logic [ALU_FUNC_W-1:0] ALU_PASSA = 4'd0;
    localparam logic [ALU_FUNC_W-1:0] ALU_ADD = 4'd1;
    localparam logic [ALU_FUNC_W-1:0] ALU_ADDU = 4'd2;
    localparam logic [ALU_FUNC_W-1:0] ALU_SUB = 4'd3;
    localparam logic [ALU_FUNC_W-1:0] ALU_SUBU = 4'd4;
    localparam logic [ALU_FUNC_W-1:0] ALU_SLT = 4'd5;
    localparam logic [ALU_FUNC_W-1:0] ALU_SLTU = 4'd6;
    localparam logic [ALU_FUNC_W-1:0] ALU_AND = 4'd7;
    localparam logic [ALU_FUNC_W-1:0] ALU_OR = 4'd8;
    localparam logic [ALU_FUNC_W-1:0] ALU_XOR = 4'd9;
    localparam logic [ALU_FUNC_W-1:0] ALU_NOR = 4'd10;
    localparam logic [ALU_FUNC_W-1:0] ALU_SLL = 4'd11;
    localparam logic [ALU_FUNC_W-1:0] ALU_SRL = 4'd12;
    localparam logic [ALU_FUNC_W-1:0] ALU_SRA = 4'd13;
    localparam logic [ALU_FUNC_W-1:0] ALU_LUI = 4'd14;
    localparam logic [ALU_FUNC_W-1:0] ALU_PASSB = 4'd15;

    localparam int BR_TYPE_W = 3; // Zero means no branch.
    localparam logic [BR_TYPE_W-1:0] BR_BEQ = 3'd1;
    localparam logic [BR_TYPE_W-1:0] BR_BNE = 3'd2;
    localparam logic [BR_TYPE_W-1:0] BR_BGEZ = 3'd3;
    localparam logic [BR_TYPE_W-1:0] BR_BLTZ = 3'd4;
    localparam logic [BR_TYPE_W-1:0] BR_BGTZ = 3'd5;
    localparam logic [BR_TYPE_W-1:0] BR_BLEZ = 3'd6;

    localparam int MSIZE_W = 2;
    localparam logic [MSIZE_W-1:0] MSIZE1 = 2'd0;
    localparam logic [MSIZE_W-1:0] MSIZE2 = 2'd1;
    localparam logic [MSIZE_W-1:0] MSIZE4 = 2'd2;

    localparam int FLAG_W = 14;
    localparam int FL_REG_WRITE = 13;
    localparam int FL_ALU_IMM = 12;
    localparam int FL_ZERO_EXT = 11;
    localparam int FL_MEM_READ = 10;
    localparam int FL_MEM_WRITE = 9;
    localparam int FL_MEM_SEXT = 8;
    localparam int FL_BRANCH = 7;
    localparam int FL_JUMP = 6;
    localparam int FL_JUMP_REG = 5;
    localparam int FL_LINK = 4;
    localparam int FL_HI_WRITE = 3;
    localparam int FL_LO_WRITE = 2;
    localparam int FL_HI_TO_REG = 1;
    localparam int FL_LO_TO_REG = 0;
endpackage

`default_nettype wire

// ==== hdl/decode_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
    import isa_pkg::*;
    import ctl_pkg::*;

    logic hit;
    logic [ALU_FUNC_W-1:0] alu_func;
    logic [FLAG_W-1:0] flags;
    logic shamt_valid;
    logic mul_to_reg;
    logic [MSIZE_W-1:0] mem_size;
    logic [BR_TYPE_W-1:0] branch_type;
    reg_addr_t src_a;
    reg_addr_t src_b;
    reg_addr_t dest;

    modport source (
        output hit, alu_func, flags, shamt_valid, mul_to_reg,
        output mem_size, branch_type, src_a, src_b, dest
    );

    modport sink (
        input hit, alu_func, flags, shamt_valid, mul_to_reg,
        input mem_size, branch_type, src_a, src_b, dest
    );
endinterface

`default_nettype wire

// ==== hdl/main_op_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_op_decoder (
    input isa_pkg::word_t instr,
    decode_if.source res
);
    import isa_pkg::*;
    import ctl_pkg::*;

    instr_u iw;

    assign iw = instr;

    always_comb begin
        res.hit = 1'b0;
        res.alu_func = ALU_PASSA;
        res.flags = '0;
        res.shamt_valid = 1'b0;
        res.mul_to_reg = 1'b0;
        res.mem_size = '0;
        res.branch_type = '0;
        res.src_a = '0;
        res.src_b = '0;
        res.dest = '0;
        case (iw.i.opcode)
            OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU,
            OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI: begin
                res.hit = 1'b1;
                res.flags[FL_REG_WRITE] = 1'b1;
                res.flags[FL_ALU_IMM] = 1'b1;
                res.flags[FL_ZERO_EXT] = iw.i.opcode inside {OPC_ANDI, OPC_ORI, OPC_XORI};
                res.src_a = iw.i.rs;
                res.dest = iw.i.rt;
                case (iw.i.opcode)
                    OPC_ADDI: res.alu_func = ALU_ADD;
                    OPC_ADDIU: res.alu_func = ALU_ADDU;
                    OPC_SLTI: res.alu_func = ALU_SLT;
                    OPC_SLTIU: res.alu_func = ALU_SLTU;
                    OPC_ANDI: res.alu_func = ALU_AND;
                    OPC_ORI: res.alu_func = ALU_OR;
                    OPC_XORI: res.alu_func = ALU_XOR;
                    default: begin
                        res.alu_func = ALU_LUI;
                        res.src_a = '0; // LUI reads no register.
                    end
                endcase
            end
            OPC_LB, OPC_LBU, OPC_LH, OPC_LHU, OPC_LW,
            OPC_SB, OPC_SH, OPC_SW: begin
                res.hit = 1'b1;
                res.flags[FL_ALU_IMM] = 1'b1;
                res.src_a = iw.i.rs; // Base register of the address.
                if (iw.i.opcode inside {OPC_SB, OPC_SH, OPC_SW}) begin
                    res.flags[FL_MEM_WRITE] = 1'b1;
                    res.src_b = iw.i.rt;
                end else begin
                    res.flags[FL_REG_WRITE] = 1'b1;
                    res.flags[FL_MEM_READ] = 1'b1;
                    res.flags[FL_MEM_SEXT] = iw.i.opcode inside {OPC_LB, OPC_LH};
                    res.dest = iw.i.rt;
                end
                case (iw.i.opcode)
                    OPC_LB, OPC_LBU, OPC_SB: res.mem_size = MSIZE1;
                    OPC_LH, OPC_LHU, OPC_SH: res.mem_size = MSIZE2;
                    default: res.mem_size = MSIZE4;
                endcase
            end
            OPC_BEQ, OPC_BNE, OPC_BGTZ, OPC_BLEZ: begin
                res.hit = 1'b1;
                res.flags[FL_BRANCH] = 1'b1;
                res.src_a = iw.i.rs;
                case (iw.i.opcode)
                    OPC_BEQ: res.branch_type = BR_BEQ;
                    OPC_BNE: res.branch_type = BR_BNE;
                    OPC_BGTZ: res.branch_type = BR_BGTZ;
                    default: res.branch_type = BR_BLEZ;
                endcase
                if (iw.i.opcode inside {OPC_BEQ, OPC_BNE}) begin
                    res.src_b = iw.i.rt; // Only these compare two registers.
                end
            end
            OPC_REGIMM: begin
                case (iw.i.rt)
                    RT_BGEZ, RT_BGEZAL: res.branch_type = BR_BGEZ;
                    RT_BLTZ, RT_BLTZAL: res.branch_type = BR_BLTZ;
                    default: res.branch_type = '0;
                endcase
                if (res.branch_type != '0) begin
                    res.hit = 1'b1;
                    res.flags[FL_BRANCH] = 1'b1;
                    res.src_a = iw.i.rs;
                end
                if (iw.i.rt inside {RT_BGEZAL, RT_BLTZAL}) begin
                    res.flags[FL_REG_WRITE] = 1'b1;
                    res.flags[FL_LINK] = 1'b1;
                    res.dest = LINK_REG;
                end
            end
            OPC_J, OPC_JAL: begin
                res.hit = 1'b1;
                res.flags[FL_JUMP] = 1'b1;
                if (iw.i.opcode == OPC_JAL) begin
                    res.flags[FL_REG_WRITE] = 1'b1;
                    res.flags[FL_LINK] = 1'b1;
                    res.dest = LINK_REG;
                end
            end
            OPC_SPECIAL2: begin
                if (iw.r.funct == FN2_MUL) begin
                    res.hit = 1'b1;
                    res.flags[FL_REG_WRITE] = 1'b1;
                    res.mul_to_reg = 1'b1; // Low product word goes straight to rd.
                    res.src_a = iw.r.rs;
                    res.src_b = iw.r.rt;
                    res.dest = iw.r.rd;
                end
            end
            default: ;
        endcase
    end
endmodule

`default_nettype wire

// ==== hdl/funct_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module funct_decoder (
    input isa_pkg::word_t instr,
    decode_if.source res
);
    import isa_pkg::*;
    import ctl_pkg::*;

    instr_u iw;

    assign iw = instr;

    always_comb begin
        res.hit = 1'b0;
        res.alu_func = ALU_PASSA;
        res.flags = '0;
        res.shamt_valid = 1'b0;
        res.mul_to_reg = 1'b0;
        res.mem_size = '0;
        res.branch_type = '0;
        res.src_a = '0;
        res.src_b = '0;
        res.dest = '0;
        if (iw.r.opcode == OPC_SPECIAL) begin
            case (iw.r.funct)
                FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
                FN_AND, FN_OR, FN_XOR, FN_NOR,
                FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: begin
                    res.hit = 1'b1;
                    res.flags[FL_REG_WRITE] = 1'b1;
                    res.shamt_valid = iw.r.funct inside {FN_SLL, FN_SRL, FN_SRA};
                    res.src_a = res.shamt_valid ? '0 : iw.r.rs; // Shamt replaces rs.
                    res.src_b = iw.r.rt;
                    res.dest = iw.r.rd;
                    case (iw.r.funct)
                        FN_ADD: res.alu_func = ALU_ADD;
                        FN_ADDU: res.alu_func = ALU_ADDU;
                        FN_SUB: res.alu_func = ALU_SUB;
                        FN_SUBU: res.alu_func = ALU_SUBU;
                        FN_SLT: res.alu_func = ALU_SLT;
                        FN_SLTU: res.alu_func = ALU_SLTU;
                        FN_AND: res.alu_func = ALU_AND;
                        FN_OR: res.alu_func = ALU_OR;
                        FN_XOR: res.alu_func = ALU_XOR;
                        FN_NOR: res.alu_func = ALU_NOR;
                        FN_SLL, FN_SLLV: res.alu_func = ALU_SLL;
                        FN_SRL, FN_SRLV: res.alu_func = ALU_SRL;
                        default: res.alu_func = ALU_SRA;
                    endcase
                end
                FN_JR, FN_JALR: begin
                    res.hit = 1'b1;
                    res.flags[FL_JUMP] = 1'b1;
                    res.flags[FL_JUMP_REG] = 1'b1;
                    res.src_a = iw.r.rs;
                    if (iw.r.funct == FN_JALR) begin
                        res.flags[FL_REG_WRITE] = 1'b1;
                        res.flags[FL_LINK] = 1'b1;
                        res.dest = iw.r.rd; // JALR names its link register.
                    end
                end
                FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
                    res.hit = 1'b1;
                    res.flags[FL_HI_WRITE] = 1'b1;
                    res.flags[FL_LO_WRITE] = 1'b1;
                    res.src_a = iw.r.rs;
                    res.src_b = iw.r.rt;
                end
                FN_MFHI, FN_MFLO: begin
                    res.hit = 1'b1;
                    res.flags[FL_REG_WRITE] = 1'b1;
                    res.dest = iw.r.rd;
                    if (iw.r.funct == FN_MFHI) begin
                        res.flags[FL_HI_TO_REG] = 1'b1;
                    end else begin
                        res.flags[FL_LO_TO_REG] = 1'b1;
                        res.alu_func = ALU_PASSB; // LO rides on the B operand path.
                    end
                end
                FN_MTHI, FN_MTLO: begin
                    res.hit = 1'b1;
                    res.flags[FL_HI_WRITE] = (iw.r.funct == FN_MTHI);
                    res.flags[FL_LO_WRITE] = (iw.r.funct == FN_MTLO);
                    res.src_a = iw.r.rs;
                end
                default: ;
            endcase
        end
    end
endmodule

`default_nettype wire

// ==== hdl/ctl_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctl_merge (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    decode_if.sink main_res,
    decode_if.sink funct_res,
    output logic out_valid,
    output logic reserved,
    output logic [ctl_pkg::ALU_FUNC_W-1:0] alu_func,
    output logic [ctl_pkg::FLAG_W-1:0] flags,
    output logic shamt_valid,
    output logic mul_to_reg,
    output logic [ctl_pkg::MSIZE_W-1:0] mem_size,
    output logic [ctl_pkg::BR_TYPE_W-1:0] branch_type,
    output isa_pkg::reg_addr_t src_a,
    output isa_pkg::reg_addr_t src_b,
    output isa_pkg::reg_addr_t dest
);
    logic miss;

    assign miss = !(main_res.hit || funct_res.hit);

    // A decoder that misses drives all zero, so a miss on both sides
    // falls through to a zero result from funct_res.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            reserved <= 1'b0;
            alu_func <= '0;
            flags <= '0;
            shamt_valid <= 1'b0;
            mul_to_reg <= 1'b0;
            mem_size <= '0;
            branch_type <= '0;
            src_a <= '0;
            src_b <= '0;
            dest <= '0;
        end else begin
            out_valid <= instr_valid;
            if (instr_valid) begin
                reserved <= miss;
                alu_func <= main_res.hit ? main_res.alu_func : funct_res.alu_func;
                flags <= main_res.hit ? main_res.flags : funct_res.flags;
                shamt_valid <= main_res.hit ? main_res.shamt_valid : funct_res.shamt_valid;
                mul_to_reg <= main_res.hit ? main_res.mul_to_reg : funct_res.mul_to_reg;
                mem_size <= main_res.hit ? main_res.mem_size : funct_res.mem_size;
                branch_type <= main_res.hit ? main_res.branch_type : funct_res.branch_type;
                src_a <= main_res.hit ? main_res.src_a : funct_res.src_a;
                src_b <= main_res.hit ? main_res.src_b : funct_res.src_b;
                dest <= main_res.hit ? main_res.dest : funct_res.dest;
            end
        end
    end
endmodule

`default_nettype wire

// ==== hdl/instr_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode_top (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input isa_pkg::word_t instr,
    output logic out_valid,
    output logic reserved,
    output logic [ctl_pkg::ALU_FUNC_W-1:0] alu_func,
    output logic reg_write,
    output logic alu_imm,
    output logic zero_ext,
    output logic mem_read,
    output logic mem_write,
    output logic mem_sext,
    output logic branch,
    output logic jump,
    output logic jump_reg,
    output logic link,
    output logic hi_write,
    output logic lo_write,
    output logic hi_to_reg,
    output logic lo_to_reg,
    output logic shamt_valid,
    output logic mul_to_reg,
    output logic [ctl_pkg::MSIZE_W-1:0] mem_size,
    output logic [ctl_pkg::BR_TYPE_W-1:0] branch_type,
    output isa_pkg::reg_addr_t src_a,
    output isa_pkg::reg_addr_t src_b,
    output isa_pkg::reg_addr_t dest
);
    decode_if main_res ();
    decode_if funct_res ();

    main_op_decoder u_main_dec (
        .instr(instr),
        .res(main_res)
    );

    funct_decoder u_funct_dec (
        .instr(instr),
        .res(funct_res)
    );

    ctl_merge u_merge (
        .clk(clk),
        .rst_n(rst_n),
        .instr_valid(instr_valid),
        .main_res(main_res),
        .funct_res(funct_res),
        .out_valid(out_valid),
        .reserved(reserved),
        .alu_func(alu_func),
        .flags({reg_write, alu_imm, zero_ext, mem_read, mem_write, mem_sext, branch,
                jump, jump_reg, link, hi_write, lo_write, hi_to_reg, lo_to_reg}),
        .shamt_valid(shamt_valid),
        .mul_to_reg(mul_to_reg),
        .mem_size(mem_size),
        .branch_type(branch_type),
        .src_a(src_a),
        .src_b(src_b),
        .dest(dest)
    );
endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk; // Half of the 4 ns period.
    end
endmodule

`default_nettype wire

// ==== tb/decode_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_assert (
    input logic clk,
    input logic rst_n,
    input logic reserved,
    input logic [ctl_pkg::FLAG_W-1:0] flags
);
    import ctl_pkg::*;

    logic any_write;

    assign any_write = flags[FL_REG_WRITE] || flags[FL_MEM_WRITE]
        || flags[FL_HI_WRITE] || flags[FL_LO_WRITE];

    reserved_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(reserved && any_write))
        else $error("reserved word carries a write flag");

    branch_not_jump: assert property (@(posedge clk) disable iff (!rst_n)
        !(flags[FL_BRANCH] && flags[FL_JUMP]))
        else $error("branch and jump are high together");
endmodule

bind ctl_merge decode_assert u_assert (
    .clk(clk),
    .rst_n(rst_n),
    .reserved(reserved),
    .flags(flags)
);

`default_nettype wire

// ==== tb/tb_instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_instr_decode;
    import isa_pkg::*;
    import ctl_pkg::*;

    localparam int GOLD_COLS = 11;
    localparam int MAX_VEC = 64;
    localparam int RESET_CYCLES = 16;

    logic clk;
    logic rst_n;
    logic instr_valid;
    word_t instr;
    logic out_valid;
    logic reserved;
    logic [ALU_FUNC_W-1:0] alu_func;
    wire [FLAG_W-1:0] flags;
    logic shamt_valid;
    logic mul_to_reg;
    logic [MSIZE_W-1:0] mem_size;
    logic [BR_TYPE_W-1:0] branch_type;
    reg_addr_t src_a;
    reg_addr_t src_b;
    reg_addr_t dest;

    logic [31:0] golden [GOLD_COLS*MAX_VEC];
    int num_vec;
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int cycle_limit;
    string flag_names [FLAG_W] = '{"lo_to_reg", "hi_to_reg", "lo_write", "hi_write", "link",
        "jump_reg", "jump", "branch", "mem_sext", "mem_write", "mem_read", "zero_ext",
        "alu_imm", "reg_write"};

    tb_clock u_clk (
        .clk(clk)
    );

    instr_decode_top uut (
        .clk(clk),
        .rst_n(rst_n),
        .instr_valid(instr_valid),
        .instr(instr),
        .out_valid(out_valid),
        .reserved(reserved),
        .alu_func(alu_func),
        .reg_write(flags[FL_REG_WRITE]),
        .alu_imm(flags[FL_ALU_IMM]),
        .zero_ext(flags[FL_ZERO_EXT]),
        .mem_read(flags[FL_MEM_READ]),
        .mem_write(flags[FL_MEM_WRITE]),
        .mem_sext(flags[FL_MEM_SEXT]),
        .branch(flags[FL_BRANCH]),
        .jump(flags[FL_JUMP]),
        .jump_reg(flags[FL_JUMP_REG]),
        .link(flags[FL_LINK]),
        .hi_write(flags[FL_HI_WRITE]),
        .lo_write(flags[FL_LO_WRITE]),
        .hi_to_reg(flags[FL_HI_TO_REG]),
        .lo_to_reg(flags[FL_LO_TO_REG]),
        .shamt_valid(shamt_valid),
        .mul_to_reg(mul_to_reg),
        .mem_size(mem_size),
        .branch_type(branch_type),
        .src_a(src_a),
        .src_b(src_b),
        .dest(dest)
    );

    // Index -1 stands for the state right after reset.
    function automatic logic [31:0] gold_field(input int idx, input int col);
        if (idx < 0) begin
            return 32'd0;
        end
        return golden[idx*GOLD_COLS + col];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: %s expected 0x%0h, got 0x%0h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic check_outputs(input logic valid_exp, input int idx);
        check_value("out_valid", 32'(valid_exp), 32'(out_valid));
        check_value("reserved", gold_field(idx, 1), 32'(reserved));
        check_value("alu_func", gold_field(idx, 2), 32'(alu_func));
        for (int b = 0; b < FLAG_W; b++) begin
            check_value(flag_names[b], (gold_field(idx, 3) >> b) & 32'd1,
                        (32'(flags) >> b) & 32'd1);
        end
        check_value("shamt_valid", gold_field(idx, 4), 32'(shamt_valid));
        check_value("mul_to_reg", gold_field(idx, 5), 32'(mul_to_reg));
        check_value("mem_size", gold_field(idx, 6), 32'(mem_size));
        check_value("branch_type", gold_field(idx, 7), 32'(branch_type));
        check_value("src_a", gold_field(idx, 8), 32'(src_a));
        check_value("src_b", gold_field(idx, 9), 32'(src_b));
        check_value("dest", gold_field(idx, 10), 32'(dest));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int next_idx;
        int sent_idx;
        int last_idx;
        logic sent_valid;
        logic drive_word;

        void'($urandom(32'hadaf904d));
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        for (int i = 0; i < GOLD_COLS*MAX_VEC; i++) begin
            golden[i] = {16'hdead, i[15:0]}; // Reserved column above 1 marks the end.
        end
        $readmemh("tb/decode_golden.txt", golden);
        num_vec = 0;
        while (num_vec < MAX_VEC && golden[num_vec*GOLD_COLS + 1] <= 32'd1) begin
            num_vec++;
        end
        cycle_limit = 4*num_vec + RESET_CYCLES + 50;
        if (num_vec == 0) begin
            $display("No test vectors were read from the golden file.");
            error_count++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_outputs(1'b0, -1);

        next_idx = 0;
        sent_idx = -1;
        last_idx = -1;
        sent_valid = 1'b0;
        while (next_idx < num_vec || sent_valid) begin
            @(posedge clk);
            drive_word = (next_idx < num_vec) && ($urandom % 4 != 0);
            if (drive_word) begin
                instr_valid <= 1'b1;
                instr <= golden[next_idx*GOLD_COLS];
            end else begin
                instr_valid <= 1'b0;
                instr <= $urandom; // Must not disturb the held outputs.
            end
            @(negedge clk);
            if (sent_valid) begin
                last_idx = sent_idx; // Accepted at the edge just passed.
            end
            check_outputs(sent_valid, last_idx);
            sent_valid = drive_word;
            if (drive_word) begin
                sent_idx = next_idx;
                next_idx++;
            end
        end
        @(posedge clk);
        @(negedge clk);
        check_outputs(1'b0, last_idx);

        $display("Vectors: %0d, checks: %0d, errors: %0d", num_vec, check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== tb/decode_golden.txt ====
// instr    rsv alu flags sv mul msz bt sa sb dst
// flags: reg_write down to lo_to_reg, one bit each, MSB first
20880005 0 1 3000 0 0 0 0 04 00 08 // ADDI
30a9ff00 0 7 3800 0 0 0 0 05 00 09 // ANDI
2c62ffff 0 6 3000 0 0 0 0 03 00 02 // SLTIU
3cea1234 0 e 3000 0 0 0 0 00 00 0a // LUI
83a8fffc 0 0 3500 0 0 0 0 1d 00 08 // LB
94850002 0 0 3400 0 0 1 0 04 00 05 // LHU
8fbf0010 0 0 3400 0 0 2 0 1d 00 1f // LW
afbf0014 0 0 1200 0 0 2 0 1d 1f 00 // SW
10220003 0 0 0080 0 0 0 1 01 02 00 // BEQ
1c60fffe 0 0 0080 0 0 0 5 03 00 00 // BGTZ
04910008 0 0 2090 0 0 0 3 04 00 1f // BGEZAL
04a00004 0 0 0080 0 0 0 4 05 00 00 // BLTZ
08100000 0 0 0040 0 0 0 0 00 00 00 // J
0c000400 0 0 2050 0 0 0 0 00 00 1f // JAL
03e00008 0 0 0060 0 0 0 0 1f 00 00 // JR
0120f809 0 0 2070 0 0 0 0 09 00 1f // JALR
00221821 0 2 2000 0 0 0 0 01 02 03 // ADDU
00031100 0 b 2000 1 0 0 0 00 03 02 // SLL
01283807 0 d 2000 0 0 0 0 09 08 07 // SRAV
00850018 0 0 000c 0 0 0 0 04 05 00 // MULT
00004010 0 0 2002 0 0 0 0 00 00 08 // MFHI
00004812 0 f 2001 0 0 0 0 00 00 09 // MFLO
70851002 0 0 2000 0 1 0 0 04 05 02 // MUL
04a20004 1 0 0000 0 0 0 0 00 00 00 // REGIMM, unknown rt
0000000d 1 0 0000 0 0 0 0 00 00 00 // BREAK
0000000c 1 0 0000 0 0 0 0 00 00 00 // SYSCALL
42000018 1 0 0000 0 0 0 0 00 00 00 // ERET
fc000000 1 0 0000 0 0 0 0 00 00 00 // unknown opcode
0000003f 1 0 0000 0 0 0 0 00 00 00 // unknown funct

// ==== sim.f ====
hdl/isa_pkg.sv
hdl/ctl_pkg.sv
hdl/decode_if.sv
hdl/main_op_decoder.sv
hdl/funct_decoder.sv
hdl/ctl_merge.sv
hdl/instr_decode_top.sv
tb/tb_clock.sv
tb/decode_assert.sv
tb/tb_instr_decode.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_instr_decode
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)
